// ==== logic/emesh_pkg.sv ====
// emesh packet constants: width, field positions and link byte count
package emesh_pkg;

  // ######################################
  // packet geometry
  // ######################################

  // bits in one emesh packet
  localparam int packet_width = 103;

  // field positions, lsb of each field
  localparam int write_bit    = 102;
  localparam int datamode_lsb = 100;
  localparam int ctrlmode_lsb = 96;
  localparam int dstaddr_lsb  = 64;
  localparam int srcaddr_lsb  = 32;
  localparam int data_lsb     = 0;

  // field widths
  localparam int datamode_width = 2;
  localparam int ctrlmode_width = 4;
  localparam int addr_width     = 32;
  localparam int data_width     = 32;

  // ######################################
  // link and buffering
  // ######################################

  // bytes per packet on the link, top pad bit is zero
  localparam int packet_bytes = 13;

  // default fifo depth, power of two
  localparam int fifo_depth = 4;

endpackage

// ==== logic/packet_fifo.sv ====
// packet fifo with first-word-fall-through reads and full and empty flags
`timescale 1ns/1ps

module packet_fifo #(
  parameter int depth = emesh_pkg::fifo_depth
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          push,
  input  logic [emesh_pkg::packet_width-1:0] push_data,
  output logic                          full,
  input  logic                          pop,
  output logic [emesh_pkg::packet_width-1:0] head,
  output logic                          empty
);
  import emesh_pkg::*;

  // pointer and occupancy widths
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  logic [packet_width-1:0] mem [depth];
  logic [ptr_w-1:0]        wr_ptr;
  logic [ptr_w-1:0]        rd_ptr;
  logic [cnt_w-1:0]        count;
  logic                    do_push;
  logic                    do_pop;

  // a push into a full buffer is dropped
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign full  = (count == cnt_w'(depth));
  assign empty = (count == '0);

  // head shown straight from storage without a read delay
  assign head = mem[rd_ptr];

  // packet storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers and count
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== logic/tx_arbiter.sv ====
// tx arbiter picks among three fifos by fixed priority, holds one packet and splits out its fields
`timescale 1ns/1ps

module tx_arbiter (
  input  logic                                 clk,
  input  logic                                 reset,
  // read response fifo
  input  logic [emesh_pkg::packet_width-1:0]   rr_head,
  input  logic                                 rr_empty,
  output logic                                 rr_rd_en,
  // read request fifo
  input  logic [emesh_pkg::packet_width-1:0]   rq_head,
  input  logic                                 rq_empty,
  output logic                                 rq_rd_en,
  // write fifo
  input  logic [emesh_pkg::packet_width-1:0]   wr_head,
  input  logic                                 wr_empty,
  output logic                                 wr_rd_en,
  // wait levels from outside
  input  logic                                 rd_wait,
  input  logic                                 wr_wait,
  // framer side
  input  logic                                 ack,
  output logic                                 access,
  output logic [emesh_pkg::packet_width-1:0]   packet,
  // broken-out emesh fields
  output logic                                 tx_write,
  output logic [emesh_pkg::datamode_width-1:0] tx_datamode,
  output logic [emesh_pkg::ctrlmode_width-1:0] tx_ctrlmode,
  output logic [emesh_pkg::addr_width-1:0]     tx_dstaddr,
  output logic [emesh_pkg::addr_width-1:0]     tx_srcaddr,
  output logic [emesh_pkg::data_width-1:0]     tx_data
);
  import emesh_pkg::*;

  logic                    rr_ready;
  logic                    rq_ready;
  logic                    wr_ready;
  logic                    can_load;
  logic [packet_width-1:0] packet_q;

  // ######################################
  // priority pick
  // ######################################

  // responses first, then requests, then writes
  assign rr_ready = ~rr_empty & ~wr_wait;
  assign rq_ready = ~rq_empty & ~rd_wait & ~rr_ready;
  assign wr_ready = ~wr_empty & ~wr_wait & ~rr_ready & ~rq_ready;

  // load when idle or when the held packet is done
  assign can_load = ~access | ack;

  assign rr_rd_en = rr_ready & can_load;
  assign rq_rd_en = rq_ready & can_load;
  assign wr_rd_en = wr_ready & can_load;

  // access flag
  always_ff @(posedge clk) begin
    if (reset) begin
      access <= 1'b0;
    end else if (rr_rd_en || rq_rd_en || wr_rd_en) begin
      access <= 1'b1;
    end else if (ack) begin
      access <= 1'b0;
    end
  end

  // held packet latched from the winning head
  always_ff @(posedge clk) begin
    if (rr_rd_en) begin
      packet_q <= rr_head;
    end else if (rq_rd_en) begin
      packet_q <= rq_head;
    end else if (wr_rd_en) begin
      packet_q <= wr_head;
    end
  end

  // ######################################
  // field break-out
  // ######################################

  assign packet      = packet_q;
  assign tx_write    = packet_q[write_bit];
  assign tx_datamode = packet_q[datamode_lsb +: datamode_width];
  assign tx_ctrlmode = packet_q[ctrlmode_lsb +: ctrlmode_width];
  assign tx_dstaddr  = packet_q[dstaddr_lsb +: addr_width];
  assign tx_srcaddr  = packet_q[srcaddr_lsb +: addr_width];
  assign tx_data     = packet_q[data_lsb +: data_width];

endmodule

// ==== logic/link_framer.sv ====
// link framer: sends the held packet as bytes on a stallable link and acks the last one
`timescale 1ns/1ps

module link_framer (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               access,
  input  logic [emesh_pkg::packet_width-1:0] packet,
  input  logic                               link_wait,
  output logic                               ack,
  output logic                               tx_frame,
  output logic [7:0]                         tx_byte
);
  import emesh_pkg::*;

  // padded packet width and byte counter width
  localparam int frame_width = packet_bytes * 8;
  localparam int cnt_w       = $clog2(packet_bytes);
  localparam int pad_width   = frame_width - packet_width;

  logic [frame_width-1:0] frame_word;
  logic [cnt_w-1:0]       byte_cnt;
  logic [cnt_w-1:0]       byte_sel;
  logic                   byte_move;
  logic                   last_byte;

  // ######################################
  // byte select
  // ######################################

  // zero pad on top up to a whole number of bytes
  assign frame_word = {{pad_width{1'b0}}, packet};

  // msb first, so count 0 picks the top byte
  assign byte_sel = cnt_w'(packet_bytes - 1) - byte_cnt;

  always_comb begin
    tx_byte = '0;
    for (int i = 0; i < packet_bytes; i++) begin
      if (byte_sel == cnt_w'(i)) begin
        tx_byte = frame_word[i*8 +: 8];
      end
    end
  end

  // ######################################
  // counter and ack
  // ######################################

  // frame simply follows the arbiter's access
  assign tx_frame = access;

  // byte leaves on every unstalled frame cycle
  assign byte_move = access & ~link_wait;
  assign last_byte = (byte_cnt == cnt_w'(packet_bytes - 1));

  // ack on the cycle the last byte leaves
  assign ack = byte_move & last_byte;

  always_ff @(posedge clk) begin
    if (reset) begin
      byte_cnt <= '0;
    end else if (byte_move) begin
      if (last_byte) begin
        // ready for a back-to-back packet
        byte_cnt <= '0;
      end else begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== logic/emesh_tx.sv ====
// emesh transmit top: three packet fifos, priority arbiter and byte link framer
`timescale 1ns/1ps

module emesh_tx #(
  parameter int fifo_depth = emesh_pkg::fifo_depth
) (
  input  logic                                 clk,
  input  logic                                 reset,
  // write channel
  input  logic                                 wr_push,
  input  logic [emesh_pkg::packet_width-1:0]   wr_data,
  output logic                                 wr_full,
  // read request channel
  input  logic                                 rq_push,
  input  logic [emesh_pkg::packet_width-1:0]   rq_data,
  output logic                                 rq_full,
  // read response channel
  input  logic                                 rr_push,
  input  logic [emesh_pkg::packet_width-1:0]   rr_data,
  output logic                                 rr_full,
  // wait levels
  input  logic                                 rd_wait,
  input  logic                                 wr_wait,
  input  logic                                 link_wait,
  // link
  output logic                                 tx_frame,
  output logic [7:0]                           tx_byte,
  // fields of the packet on the link
  output logic                                 tx_write,
  output logic [emesh_pkg::datamode_width-1:0] tx_datamode,
  output logic [emesh_pkg::ctrlmode_width-1:0] tx_ctrlmode,
  output logic [emesh_pkg::addr_width-1:0]     tx_dstaddr,
  output logic [emesh_pkg::addr_width-1:0]     tx_srcaddr,
  output logic [emesh_pkg::data_width-1:0]     tx_data
);
  import emesh_pkg::*;

  // fifo heads and handshake levels
  logic [packet_width-1:0] wr_head;
  logic [packet_width-1:0] rq_head;
  logic [packet_width-1:0] rr_head;
  logic                    wr_empty;
  logic                    rq_empty;
  logic                    rr_empty;
  logic                    wr_rd_en;
  logic                    rq_rd_en;
  logic                    rr_rd_en;

  // arbiter to framer
  logic                    access;
  logic                    ack;
  logic [packet_width-1:0] packet;

  // ######################################
  // channel fifos
  // ######################################

  packet_fifo #(.depth(fifo_depth)) u_wr_fifo (
    .clk(clk), .reset(reset),
    .push(wr_push), .push_data(wr_data), .full(wr_full),
    .pop(wr_rd_en), .head(wr_head), .empty(wr_empty)
  );

  packet_fifo #(.depth(fifo_depth)) u_rq_fifo (
    .clk(clk), .reset(reset),
    .push(rq_push), .push_data(rq_data), .full(rq_full),
    .pop(rq_rd_en), .head(rq_head), .empty(rq_empty)
  );

  packet_fifo #(.depth(fifo_depth)) u_rr_fifo (
    .clk(clk), .reset(reset),
    .push(rr_push), .push_data(rr_data), .full(rr_full),
    .pop(rr_rd_en), .head(rr_head), .empty(rr_empty)
  );

  // ######################################
  // arbiter and framer
  // ######################################

  tx_arbiter u_tx_arbiter (
    .clk(clk), .reset(reset),
    .rr_head(rr_head), .rr_empty(rr_empty), .rr_rd_en(rr_rd_en),
    .rq_head(rq_head), .rq_empty(rq_empty), .rq_rd_en(rq_rd_en),
    .wr_head(wr_head), .wr_empty(wr_empty), .wr_rd_en(wr_rd_en),
    .rd_wait(rd_wait), .wr_wait(wr_wait),
    .ack(ack), .access(access), .packet(packet),
    .tx_write(tx_write), .tx_datamode(tx_datamode), .tx_ctrlmode(tx_ctrlmode),
    .tx_dstaddr(tx_dstaddr), .tx_srcaddr(tx_srcaddr), .tx_data(tx_data)
  );

  link_framer u_link_framer (
    .clk(clk), .reset(reset),
    .access(access), .packet(packet), .link_wait(link_wait),
    .ack(ack), .tx_frame(tx_frame), .tx_byte(tx_byte)
  );

endmodule

// ==== sim/tb_clock.sv ====
// testbench clock and reset generator, reset held high for the first few cycles
`timescale 1ns/1ps

module tb_clock #(
  parameter int period       = 100,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic reset
);

  // free-running clock, first rising edge at half a period
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // released on a falling edge, well away from the rising edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// ==== sim/emesh_tx_tb.sv ====
// emesh tx testbench: runs the input script, rebuilds link packets and checks their order
`timescale 1ns/1ps

module emesh_tx_tb;
  import emesh_pkg::*;

  localparam int depth         = 4;
  localparam int line_chars    = 128;
  localparam int margin_cycles = 200;
  localparam int frame_width   = packet_bytes * 8;

  logic                      clk;
  logic                      reset;
  logic                      wr_push;
  logic                      rq_push;
  logic                      rr_push;
  logic [packet_width-1:0]   wr_data;
  logic [packet_width-1:0]   rq_data;
  logic [packet_width-1:0]   rr_data;
  logic                      wr_full;
  logic                      rq_full;
  logic                      rr_full;
  logic                      rd_wait;
  logic                      wr_wait;
  logic                      link_wait;
  logic                      tx_frame;
  logic [7:0]                tx_byte;
  logic                      tx_write;
  logic [datamode_width-1:0] tx_datamode;
  logic [ctrlmode_width-1:0] tx_ctrlmode;
  logic [addr_width-1:0]     tx_dstaddr;
  logic [addr_width-1:0]     tx_srcaddr;
  logic [data_width-1:0]     tx_data;

  // script lines and packets in departure order
  logic [8*line_chars-1:0]   script [$];
  logic [packet_width-1:0]   expected [$];
  logic [frame_width-1:0]    frame_bits;
  logic [15:0]               lfsr_state;
  int                        budget_cycles;
  int                        rx_count;
  int                        byte_idx;
  int                        value_errors;
  int                        missing_errors;
  int                        script_errors;

  tb_clock #(.period(100), .reset_cycles(3)) u_clock (.clk(clk), .reset(reset));

  emesh_tx #(.fifo_depth(depth)) u_dut (
    .clk(clk), .reset(reset),
    .wr_push(wr_push), .wr_data(wr_data), .wr_full(wr_full),
    .rq_push(rq_push), .rq_data(rq_data), .rq_full(rq_full),
    .rr_push(rr_push), .rr_data(rr_data), .rr_full(rr_full),
    .rd_wait(rd_wait), .wr_wait(wr_wait), .link_wait(link_wait),
    .tx_frame(tx_frame), .tx_byte(tx_byte),
    .tx_write(tx_write), .tx_datamode(tx_datamode), .tx_ctrlmode(tx_ctrlmode),
    .tx_dstaddr(tx_dstaddr), .tx_srcaddr(tx_srcaddr), .tx_data(tx_data)
  );

  // ######################################
  // helpers
  // ######################################

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic clear_pushes();
    wr_push = 1'b0;
    rq_push = 1'b0;
    rr_push = 1'b0;
  endtask

  // first pass, keep command lines, collect expected packets and the time budget
  task automatic load_script(output logic opened);
    int                      fd;
    int                      n;
    int                      count;
    int                      total;
    logic [8*line_chars-1:0] line;
    logic [7:0]              cmd;
    logic [frame_width-1:0]  value;
    fd = $fopen("sim/emesh_tx_input.txt", "r");
    opened = (fd != 0);
    if (opened) begin
      total = margin_cycles;
      while (!$feof(fd)) begin
        line = '0;
        n = $fgets(line, fd);
        cmd = 8'h00;
        n = $sscanf(line, "%s", cmd);
        if (n == 1 && cmd != "#") begin
          script.push_back(line);
          if (cmd == "e") begin
            n = $sscanf(line, "%s %h", cmd, value);
            expected.push_back(value[packet_width-1:0]);
            total += packet_bytes;
          end else if (cmd == "i" || cmd == "r") begin
            n = $sscanf(line, "%s %d", cmd, count);
            total += count;
          end else begin
            total += 1;
          end
        end
      end
      $fclose(fd);
      budget_cycles = total;
    end
  endtask

  // second pass, every timed command starts on a falling edge
  task automatic run_script();
    int                     n;
    int                     a;
    int                     b;
    int                     c;
    logic [7:0]             cmd;
    logic [7:0]             ch;
    logic [frame_width-1:0] value;
    logic                   full_now;
    foreach (script[k]) begin
      cmd = 8'h00;
      n = $sscanf(script[k], "%s", cmd);
      case (cmd)
        "p": begin
          n = $sscanf(script[k], "%s %s %h", cmd, ch, value);
          @(negedge clk);
          clear_pushes();
          case (ch)
            "w": begin
              wr_push = 1'b1;
              wr_data = value[packet_width-1:0];
            end
            "q": begin
              rq_push = 1'b1;
              rq_data = value[packet_width-1:0];
            end
            "r": begin
              rr_push = 1'b1;
              rr_data = value[packet_width-1:0];
            end
            default: begin
              $display("script push names an unknown channel '%s'", ch);
              script_errors++;
            end
          endcase
        end
        "w": begin
          n = $sscanf(script[k], "%s %d %d %d", cmd, a, b, c);
          @(negedge clk);
          clear_pushes();
          rd_wait   = a[0];
          wr_wait   = b[0];
          link_wait = c[0];
        end
        "i": begin
          n = $sscanf(script[k], "%s %d", cmd, a);
          repeat (a) begin
            @(negedge clk);
            clear_pushes();
          end
        end
        // random stalls, one lfsr step per link_wait bit
        "r": begin
          n = $sscanf(script[k], "%s %d", cmd, a);
          repeat (a) begin
            @(negedge clk);
            clear_pushes();
            lfsr_state = lfsr_step(lfsr_state);
            link_wait  = lfsr_state[0];
          end
        end
        "f": begin
          n = $sscanf(script[k], "%s %s %d", cmd, ch, a);
          @(negedge clk);
          clear_pushes();
          full_now = (ch == "w") ? wr_full : (ch == "q") ? rq_full : rr_full;
          if (full_now !== a[0]) begin
            $display("FAILED %0t: full flag of channel %s is %b, expected %b",
                     $time, ch, full_now, a[0]);
            value_errors++;
          end
        end
        "e": begin
        end
        default: begin
          $display("script holds an unknown command '%s'", cmd);
          script_errors++;
        end
      endcase
    end
  endtask

  // release all waits and give the link time to empty
  task automatic drain_link();
    int limit;
    int waited;
    @(negedge clk);
    clear_pushes();
    rd_wait   = 1'b0;
    wr_wait   = 1'b0;
    link_wait = 1'b0;
    limit  = (expected.size() - rx_count) * packet_bytes + 50;
    waited = 0;
    while (rx_count < expected.size() && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    // catches extra packets too
    repeat (20) @(posedge clk);
    if (rx_count < expected.size()) begin
      $display("only %0d of %0d expected packets left on the link", rx_count, expected.size());
      missing_errors += expected.size() - rx_count;
    end
  endtask

  // ######################################
  // processes
  // ######################################

  initial begin : main_flow
    logic opened;
    clear_pushes();
    wr_data        = '0;
    rq_data        = '0;
    rr_data        = '0;
    rd_wait        = 1'b0;
    wr_wait        = 1'b0;
    link_wait      = 1'b0;
    lfsr_state     = 16'd64055;
    budget_cycles  = 0;
    value_errors   = 0;
    missing_errors = 0;
    script_errors  = 0;
    load_script(opened);
    if (!opened) begin
      $display("could not open sim/emesh_tx_input.txt for reading");
      $display("TEST FAIL");
      $finish;
    end else begin
      wait (!reset);
      run_script();
      drain_link();
      $display("errors: %0d wrong values, %0d missing packets, %0d bad script lines",
               value_errors, missing_errors, script_errors);
      if (value_errors + missing_errors + script_errors == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

  // byte monitor, a byte moves on a rising edge with frame high and no stall
  initial begin
    rx_count   = 0;
    byte_idx   = 0;
    frame_bits = '0;
    forever begin
      @(posedge clk);
      if (!reset && tx_frame && !link_wait) begin
        if (rx_count < expected.size()) begin
          if ({tx_write, tx_datamode, tx_ctrlmode, tx_dstaddr, tx_srcaddr, tx_data} !==
              {expected[rx_count][write_bit],
               expected[rx_count][datamode_lsb +: datamode_width],
               expected[rx_count][ctrlmode_lsb +: ctrlmode_width],
               expected[rx_count][dstaddr_lsb +: addr_width],
               expected[rx_count][srcaddr_lsb +: addr_width],
               expected[rx_count][data_lsb +: data_width]}) begin
            $display("FAILED %0t: field outputs wrong for packet %0d", $time, rx_count);
            value_errors++;
          end
        end
        if (byte_idx == 0 && tx_byte[7] !== 1'b0) begin
          $display("FAILED %0t: pad bit of packet %0d is not zero", $time, rx_count);
          value_errors++;
        end
        frame_bits = {frame_bits[frame_width-9:0], tx_byte};
        byte_idx++;
        if (byte_idx == packet_bytes) begin
          if (rx_count >= expected.size()) begin
            $display("FAILED %0t: unexpected packet %h", $time, frame_bits);
            value_errors++;
          end else if (frame_bits !== {1'b0, expected[rx_count]}) begin
            $display("FAILED %0t: packet %0d is %h, expected %h",
                     $time, rx_count, frame_bits, {1'b0, expected[rx_count]});
            value_errors++;
          end
          rx_count++;
          byte_idx = 0;
        end
      end
    end
  end

  // idle outputs during and just after reset, skipping the first edge
  initial begin
    @(posedge clk);
    repeat (5) begin
      @(posedge clk);
      if (tx_frame !== 1'b0 || wr_full !== 1'b0 || rq_full !== 1'b0 || rr_full !== 1'b0) begin
        $display("FAILED %0t: frame or full flag not low around reset", $time);
        value_errors++;
      end
    end
  end

  // watchdog, budget from packets, idle cycles and script length
  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d packets received",
             budget_cycles, rx_count, expected.size());
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== emesh_tx.f ====
logic/emesh_pkg.sv
logic/packet_fifo.sv
logic/tx_arbiter.sv
logic/link_framer.sv
logic/emesh_tx.sv
sim/tb_clock.sv
sim/emesh_tx_tb.sv

// ==== sim/emesh_tx_input.txt ====
# p <chan w|q|r> <hex packet> | w <rd_wait> <wr_wait> <link_wait> | i <cycles> idle
# r <cycles> random link_wait | e <hex packet> expected in order | f <chan> <full value>
f w 0
f q 0
f r 0
# fixed priority, load with every wait held
w 1 1 1
p w 63800030000000c00112345678
p q 10800020000000b00100000000
p r 21800010000000a001c0de0001
p w 7f800030040000c002deadbeef
p q 10800020040000b00200000000
p r 21800010040000a002c0de0002
w 0 0 0
i 90
e 21800010000000a001c0de0001
e 21800010040000a002c0de0002
e 10800020000000b00100000000
e 10800020040000b00200000000
e 63800030000000c00112345678
e 7f800030040000c002deadbeef
# rd_wait holds requests back
w 1 1 1
p r 21800010080000a003c0de0003
p q 10800020080000b00300000000
p w 63800030080000c00300000003
w 1 0 0
i 40
w 0 0 0
i 20
e 21800010080000a003c0de0003
e 63800030080000c00300000003
e 10800020080000b00300000000
# wr_wait lets only requests go
w 1 1 1
p r 218000100c0000a004c0de0004
p q 108000200c0000b00400000000
p w 638000300c0000c00400000004
w 0 1 0
i 20
w 0 0 0
i 35
e 108000200c0000b00400000000
e 218000100c0000a004c0de0004
e 638000300c0000c00400000004
# random link stalls
w 1 1 1
p r 21800010100000a005c0de0005
p w 7c800030100000c005a5a5a5a5
p q 10800020100000b00500000000
p r 21800010140000a006c0de0006
p w 63800030140000c0065a5a5a5a
w 0 0 0
r 220
w 0 0 0
i 10
e 21800010100000a005c0de0005
e 21800010140000a006c0de0006
e 10800020100000b00500000000
e 7c800030100000c005a5a5a5a5
e 63800030140000c0065a5a5a5a
# write fifo overfilled by one, the last push is dropped
w 0 1 1
p w 63800030200000c00700000007
p w 63800030240000c00800000008
p w 63800030280000c00900000009
p w 638000302c0000c00a0000000a
p w 63800030300000c00b0000000b
f w 1
f q 0
f r 0
w 0 0 0
i 70
f w 0
e 63800030200000c00700000007
e 63800030240000c00800000008
e 63800030280000c00900000009
e 638000302c0000c00a0000000a
